// ==== source/icache_pkg.sv ====
package icache_pkg;

    // ------------------------------------------------------------
    // cache geometry
    // ------------------------------------------------------------

    localparam int TAG_W    = 21;              // upper address bits kept per line.
    localparam int INDEX_W  = 7;               // selects one of the cache lines.
    localparam int OFFSET_W = 4;               // byte position inside a line.

    localparam int LINE_COUNT     = 1 << INDEX_W;  // 128 lines in the direct map.
    localparam int WORDS_PER_LINE = 4;             // one data bank per word.
    localparam int BLOCK_W        = 32 * WORDS_PER_LINE;

    // ------------------------------------------------------------
    // fetch address, seen as one word or as its cache fields
    // ------------------------------------------------------------

    typedef union packed {
        logic [31:0] raw;                      // used for whole address compares.
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } fields;
    } fetch_addr_t;

endpackage

// ==== source/icache_bank.sv ====
module icache_bank (
    input  logic                           clk_i,
    input  logic                           en_i,
    input  logic                           we_i,
    input  logic [icache_pkg::INDEX_W-1:0] index_i,
    input  logic [31:0]                    wdata_i,
    output logic [31:0]                    rdata_o
);
    import icache_pkg::*;

    // ------------------------------------------------------------
    // single-port word array, one entry per cache line
    // ------------------------------------------------------------

    logic [31:0] mem_q [LINE_COUNT];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[index_i] <= wdata_i;     // refill word for this bank.
            end else begin
                rdata_o <= mem_q[index_i];     // read data appears a cycle later.
            end
        end
    end

endmodule

// ==== source/fetch_aligner.sv ====
module fetch_aligner (
    input  logic [icache_pkg::BLOCK_W-1:0]  bank_data_i,
    input  logic [icache_pkg::BLOCK_W-1:0]  fill_block_i,
    input  logic                            use_fill_i,
    input  logic [icache_pkg::OFFSET_W-1:0] offset_i,
    output logic [31:0]                     instr_o
);
    import icache_pkg::*;

    logic [BLOCK_W-1:0] line_data;

    // on a refill the block comes straight from memory.
    assign line_data = use_fill_i ? fill_block_i : bank_data_i;

    // ------------------------------------------------------------
    // byte extraction, little-endian, wrapping inside the line
    // ------------------------------------------------------------

    for (genvar b = 0; b < 4; b++) begin : g_byte
        logic [OFFSET_W-1:0] sel;

        assign sel = offset_i + OFFSET_W'(b);  // wraps at the end of the line.
        assign instr_o[8*b +: 8] = line_data[{sel, 3'b000} +: 8];
    end

endmodule

// ==== source/main_memory.sv ====
module main_memory #(
    parameter int unsigned MEM_WORDS   = 1024,
    parameter int unsigned MEM_LATENCY = 6
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           req_i,
    input  logic [31:0]                    addr_i,
    input  logic                           load_en_i,
    input  logic [31:0]                    load_addr_i,
    input  logic [31:0]                    load_data_i,
    output logic                           ready_o,
    output logic                           fill_valid_o,
    output logic [icache_pkg::BLOCK_W-1:0] block_o
);
    import icache_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);
    localparam int CNT_W  = $clog2(MEM_LATENCY + 1);
    localparam int WSEL_W = $clog2(WORDS_PER_LINE);

    logic [31:0]          mem_q [MEM_WORDS];
    logic [31-OFFSET_W:0] line_q;
    logic [CNT_W-1:0]     count_q;
    logic                 busy_q;

    // word addresses wrap around the memory size.
    function automatic logic [ADDR_W-1:0] wrap_word(input logic [31:0] word_addr);
        return ADDR_W'(word_addr % MEM_WORDS);
    endfunction

    // ------------------------------------------------------------
    // program load port
    // ------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (load_en_i) begin
            mem_q[wrap_word(load_addr_i)] <= load_data_i;
        end
    end

    // ------------------------------------------------------------
    // block read with a fixed latency
    // ------------------------------------------------------------

    assign ready_o      = !busy_q && !load_en_i;
    assign fill_valid_o = busy_q && (count_q == '0);  // MEM_LATENCY cycles after req_i.

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_q  <= 1'b0;
            count_q <= '0;
        end else if (busy_q) begin
            if (count_q == '0) begin
                busy_q <= 1'b0;                // block was presented this cycle.
            end else begin
                count_q <= count_q - 1'b1;
            end
        end else if (req_i && ready_o) begin
            busy_q  <= 1'b1;
            count_q <= CNT_W'(MEM_LATENCY - 1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i && ready_o) begin
            line_q <= addr_i[31:OFFSET_W];     // the low offset bits are dropped.
        end
    end

    for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_word
        assign block_o[32*w +: 32] = mem_q[wrap_word({line_q, WSEL_W'(w)})];
    end

endmodule

// ==== source/icache_ctrl.sv ====
module icache_ctrl (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            stall_i,
    input  logic [31:0]                     fetch_addr_i,
    input  logic [31:0]                     check_addr_i,
    input  logic                            mem_ready_i,
    input  logic                            mem_fill_valid_i,
    input  logic [icache_pkg::BLOCK_W-1:0]  mem_block_i,
    output logic                            mem_req_o,
    output logic [31:0]                     mem_addr_o,
    output logic                            bank_en_o,
    output logic                            bank_we_o,
    output logic [icache_pkg::INDEX_W-1:0]  bank_index_o,
    output logic [icache_pkg::BLOCK_W-1:0]  bank_wdata_o,
    output logic                            use_fill_o,
    output logic [icache_pkg::OFFSET_W-1:0] offset_o,
    output logic                            instr_valid_o,
    output logic                            ready_o
);
    import icache_pkg::*;

    localparam logic [1:0] IDLE   = 2'd0;
    localparam logic [1:0] LOOKUP = 2'd1;
    localparam logic [1:0] REFILL = 2'd2;

    logic [1:0]            state_q;
    logic [1:0]            state_d;
    fetch_addr_t           fetch_addr;
    fetch_addr_t           addr_q;
    logic [TAG_W-1:0]      tag_mem [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;
    logic                  accept;
    logic                  hit;
    logic                  fill_write;

    // ------------------------------------------------------------
    // address views and lookup compare
    // ------------------------------------------------------------

    assign fetch_addr.raw = fetch_addr_i;

    assign accept     = (state_q == IDLE) && !stall_i;
    assign fill_write = (state_q == REFILL) && mem_fill_valid_i;

    // the tag array is read combinationally, next to the bank output.
    assign hit = valid_q[addr_q.fields.index] &&
                 (tag_mem[addr_q.fields.index] == addr_q.fields.tag);

    // ------------------------------------------------------------
    // lookup and refill FSM
    // ------------------------------------------------------------

    always_comb begin
        state_d       = state_q;
        mem_req_o     = 1'b0;
        bank_en_o     = 1'b0;
        bank_we_o     = 1'b0;
        bank_index_o  = addr_q.fields.index;
        instr_valid_o = 1'b0;

        case (state_q)
            IDLE: begin
                if (accept) begin
                    bank_en_o    = 1'b1;       // start the bank read at once.
                    bank_index_o = fetch_addr.fields.index;
                    state_d      = LOOKUP;
                end
            end

            LOOKUP: begin
                if (stall_i) begin
                    bank_en_o = 1'b1;          // keep the same line on the bank outputs.
                end else if (hit) begin
                    instr_valid_o = 1'b1;
                    state_d       = IDLE;
                end else if (mem_ready_i) begin
                    mem_req_o = 1'b1;
                    state_d   = REFILL;
                end
            end

            REFILL: begin
                if (mem_fill_valid_i) begin
                    bank_en_o = 1'b1;
                    bank_we_o = 1'b1;
                    // forward only if the fetch stage was not redirected.
                    instr_valid_o = (check_addr_i == addr_q.raw);
                    state_d       = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            valid_q <= '0;                     // the whole cache is empty after reset.
        end else begin
            state_q <= state_d;
            if (fill_write) begin
                valid_q[addr_q.fields.index] <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // captured address and tag array
    // ------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= fetch_addr;
        end
        if (fill_write) begin
            tag_mem[addr_q.fields.index] <= addr_q.fields.tag;
        end
    end

    // the refill block is cut into word slices at the banks.
    assign bank_wdata_o = mem_block_i;

    assign mem_addr_o = {addr_q.fields.tag, addr_q.fields.index, {OFFSET_W{1'b0}}};
    assign use_fill_o = (state_q == REFILL);
    assign offset_o   = addr_q.fields.offset;
    assign ready_o    = (state_q == IDLE);

endmodule

// ==== source/icache_top.sv ====
module icache_top #(
    parameter int unsigned MEM_WORDS   = 1024,
    parameter int unsigned MEM_LATENCY = 6
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        stall_i,
    input  logic [31:0] fetch_addr_i,
    input  logic [31:0] check_addr_i,
    input  logic        load_en_i,
    input  logic [31:0] load_addr_i,
    input  logic [31:0] load_data_i,
    output logic [31:0] instr_o,
    output logic        instr_valid_o,
    output logic        ready_o
);
    import icache_pkg::*;

    logic                mem_req;
    logic [31:0]         mem_addr;
    logic                mem_ready;
    logic                mem_fill_valid;
    logic [BLOCK_W-1:0]  mem_block;
    logic                bank_en;
    logic                bank_we;
    logic [INDEX_W-1:0]  bank_index;
    logic [BLOCK_W-1:0]  bank_wdata;
    logic [BLOCK_W-1:0]  bank_rdata;
    logic                use_fill;
    logic [OFFSET_W-1:0] offset;

    icache_ctrl u_icache_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .fetch_addr_i     (fetch_addr_i),
        .check_addr_i     (check_addr_i),
        .mem_ready_i      (mem_ready),
        .mem_fill_valid_i (mem_fill_valid),
        .mem_block_i      (mem_block),
        .mem_req_o        (mem_req),
        .mem_addr_o       (mem_addr),
        .bank_en_o        (bank_en),
        .bank_we_o        (bank_we),
        .bank_index_o     (bank_index),
        .bank_wdata_o     (bank_wdata),
        .use_fill_o       (use_fill),
        .offset_o         (offset),
        .instr_valid_o    (instr_valid_o),
        .ready_o          (ready_o)
    );

    // ------------------------------------------------------------
    // data array, bank 0 holds the lowest word of each line
    // ------------------------------------------------------------

    for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
        icache_bank u_icache_bank (
            .clk_i   (clk_i),
            .en_i    (bank_en),
            .we_i    (bank_we),
            .index_i (bank_index),
            .wdata_i (bank_wdata[32*b +: 32]),
            .rdata_o (bank_rdata[32*b +: 32])
        );
    end

    fetch_aligner u_fetch_aligner (
        .bank_data_i  (bank_rdata),
        .fill_block_i (mem_block),
        .use_fill_i   (use_fill),
        .offset_i     (offset),
        .instr_o      (instr_o)
    );

    main_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_main_memory (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (mem_req),
        .addr_i       (mem_addr),
        .load_en_i    (load_en_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .ready_o      (mem_ready),
        .fill_valid_o (mem_fill_valid),
        .block_o      (mem_block)
    );

endmodule

// ==== test/icache_sva.sv ====
module icache_sva (
    input logic clk_i,
    input logic rst_i,
    input logic stall_i,
    input logic mem_ready_i,
    input logic mem_req_o,
    input logic instr_valid_o,
    input logic ready_o
);

    int fail_count = 0;

    // ------------------------------------------------------------
    // controller rules
    // ------------------------------------------------------------

    a_req_needs_ready: assert property (
        @(posedge clk_i) disable iff (!rst_i) mem_req_o |-> mem_ready_i
    ) else begin
        $error("mem_req_o raised while main memory was not ready");
        fail_count++;
    end

    // a delivered instruction always belongs to a lookup or a refill.
    a_valid_not_idle: assert property (
        @(posedge clk_i) disable iff (!rst_i) instr_valid_o |-> !ready_o
    ) else begin
        $error("instr_valid_o raised while the cache was idle");
        fail_count++;
    end

    a_no_req_in_stall: assert property (
        @(posedge clk_i) disable iff (!rst_i) stall_i |-> !mem_req_o
    ) else begin
        $error("mem_req_o raised during a stall");
        fail_count++;
    end

endmodule

bind icache_ctrl icache_sva u_icache_sva (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .stall_i       (stall_i),
    .mem_ready_i   (mem_ready_i),
    .mem_req_o     (mem_req_o),
    .instr_valid_o (instr_valid_o),
    .ready_o       (ready_o)
);

// ==== test/icache_tb.sv ====
module icache_tb;
    import icache_pkg::*;

    localparam int MEM_WORDS   = 1024;
    localparam int MEM_LATENCY = 6;
    // about 600 accesses of up to 12 cycles each, with a margin of 4, rounded up.
    localparam int TIMEOUT_CYCLES = 30000;

    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    logic [31:0] fetch_addr_i;
    logic [31:0] check_addr_i;
    logic        load_en_i;
    logic [31:0] load_addr_i;
    logic [31:0] load_data_i;
    logic [31:0] instr_o;
    logic        instr_valid_o;
    logic        ready_o;

    logic [31:0]           mem_model [MEM_WORDS];
    logic [TAG_W-1:0]      tag_model [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_model;
    logic [31:0]           used_addrs [$];
    int                    seed;
    int                    checks;
    int                    errors;
    int                    test_checks;
    int                    test_errors;
    int                    cycle_count;

    icache_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_icache_top (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .fetch_addr_i  (fetch_addr_i),
        .check_addr_i  (check_addr_i),
        .load_en_i     (load_en_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .ready_o       (ready_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    // four bytes, little-endian, wrapping inside the 16-byte line.
    function automatic logic [31:0] expected_instr(input logic [31:0] addr);
        fetch_addr_t a;
        logic [31:0] result;
        logic [31:0] word_addr;
        int          pos;

        a.raw  = addr;
        result = '0;
        for (int b = 0; b < 4; b++) begin
            pos       = (int'(a.fields.offset) + b) % 16;
            word_addr = {a.fields.tag, a.fields.index, 2'b00} + 32'(pos / 4);
            result[8*b +: 8] = mem_model[word_addr % MEM_WORDS][8*(pos % 4) +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        test_checks++;
        if (actual !== expected) begin
            test_errors++;
            $display("FAILED at time %0t: %s: got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        checks      += test_checks;
        errors      += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    task automatic apply_reset();
        rst_i   = 1'b0;
        stall_i = 1'b1;
        repeat (8) @(negedge clk_i);
        rst_i       = 1'b1;
        valid_model = '0;
    endtask

    task automatic load_memory();
        load_en_i = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = $random(seed);
            load_addr_i  = 32'(i);
            load_data_i  = mem_model[i];
            @(negedge clk_i);
        end
        load_en_i = 1'b0;
    endtask

    // issues one address and follows the cache until it is idle again.
    task automatic fetch_once(input logic [31:0] addr, input bit random_stall,
                              input bit redirect, output logic [31:0] instr,
                              output int latency, output int valid_count);
        int cycles;
        bit done;

        cycles      = 0;
        latency     = 0;
        valid_count = 0;
        instr       = '0;
        done        = 1'b0;
        while (!ready_o) begin
            @(negedge clk_i);
        end
        fetch_addr_i = addr;
        check_addr_i = redirect ? (addr ^ 32'h0000_0010) : addr;
        stall_i      = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            cycles++;
            if (instr_valid_o) begin
                valid_count++;
                if (valid_count == 1) begin
                    latency = cycles;
                    instr   = instr_o;
                end
            end
            if (ready_o) begin
                stall_i = 1'b1;                // an idle cache would take the address again.
                done    = 1'b1;
            end else if (random_stall && valid_count == 0) begin
                stall_i = ($random(seed) & 1) != 0;
            end
        end
    endtask

    task automatic check_access(input logic [31:0] addr, input bit random_stall,
                                input bit redirect);
        fetch_addr_t a;
        logic [31:0] instr;
        int          latency;
        int          valid_count;
        bit          hit;

        a.raw = addr;
        hit   = valid_model[a.fields.index] && (tag_model[a.fields.index] == a.fields.tag);
        fetch_once(addr, random_stall, redirect, instr, latency, valid_count);
        if (redirect && !hit) begin
            check_value(32'(valid_count), 32'd0, $sformatf("valid after redirect %h", addr));
        end else begin
            check_value(32'(valid_count), 32'd1, $sformatf("valid pulses for %h", addr));
            check_value(instr, expected_instr(addr), $sformatf("instruction at %h", addr));
            if (!random_stall) begin
                check_value(32'(latency == 1), 32'(hit), $sformatf("one-cycle hit %h", addr));
            end
        end
        // the line is filled whether it was forwarded or not.
        valid_model[a.fields.index] = 1'b1;
        tag_model[a.fields.index]   = a.fields.tag;
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        logic [31:0] addr;
        logic [31:0] base;
        fetch_addr_t a;
        fetch_addr_t b;

        clk_i        = 1'b0;
        rst_i        = 1'b0;
        stall_i      = 1'b1;
        fetch_addr_i = '0;
        check_addr_i = '0;
        load_en_i    = 1'b0;
        load_addr_i  = '0;
        load_data_i  = '0;
        seed         = 32'h61d7;
        checks       = 0;
        errors       = 0;
        test_checks  = 0;
        test_errors  = 0;
        cycle_count  = 0;

        apply_reset();
        load_memory();

        for (int i = 0; i < 120; i++) begin
            addr = $random(seed);
            used_addrs.push_back(addr);
            check_access(addr, 1'b0, 1'b0);
        end
        report_test("cold misses");

        for (int i = 0; i < 30; i++) begin
            addr = used_addrs[($random(seed) & 32'h7fff_ffff) % used_addrs.size()];
            check_access(addr, 1'b0, 1'b0);
            check_access(addr, 1'b0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            base = $random(seed) & ~32'hf;
            for (int off = 0; off < 16; off++) begin
                check_access(base | 32'(off), 1'b0, 1'b0);
            end
        end
        report_test("hits");

        for (int i = 0; i < 30; i++) begin
            a.raw          = $random(seed);
            b.raw          = $random(seed);
            b.fields.index = a.fields.index;
            if (b.fields.tag == a.fields.tag) begin
                b.fields.tag = ~a.fields.tag;
            end
            check_access(a.raw, 1'b0, 1'b0);
            check_access(b.raw, 1'b0, 1'b0);
            check_access(a.raw, 1'b0, 1'b0);
            check_access(b.raw, 1'b0, 1'b0);
        end
        report_test("conflicts");

        for (int i = 0; i < 20; i++) begin
            a.raw          = $random(seed);
            b.raw          = $random(seed);
            b.fields.index = a.fields.index;
            b.fields.tag   = ~a.fields.tag;   // evicts a, so the next fetch of a misses.
            check_access(b.raw, 1'b0, 1'b0);
            check_access(a.raw, 1'b0, 1'b1);
            check_access(a.raw, 1'b0, 1'b0);
        end
        report_test("redirect");

        for (int i = 0; i < 60; i++) begin
            if (($random(seed) & 1) != 0) begin
                addr = $random(seed);
            end else begin
                addr = used_addrs[($random(seed) & 32'h7fff_ffff) % used_addrs.size()];
            end
            check_access(addr, 1'b1, 1'b0);
        end
        report_test("stall");

        apply_reset();
        load_memory();
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 40; i++) begin
                check_access(used_addrs[i], 1'b0, 1'b0);
            end
        end
        report_test("reset");

        check_value(32'(u_icache_top.u_icache_ctrl.u_icache_sva.fail_count), 32'd0,
                    "concurrent assertion failures");
        report_test("assertions");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== icache.f ====
source/icache_pkg.sv
source/icache_bank.sv
source/fetch_aligner.sv
source/main_memory.sv
source/icache_ctrl.sv
source/icache_top.sv
test/icache_sva.sv
test/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -f icache.f -o icache_sim
out=$(./obj_dir/icache_sim +verilator+error+limit+100)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "PASS: all tests"
